/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu \
    -Mdir obj_dir -o tb_cpu_sim -f src.f &&
./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* src.f */
verilog/cpu_pkg.sv
verilog/cpu_regfile.sv
verilog/r0_alu.sv
verilog/mem_controller.sv
verilog/cpu_sequencer.sv
verilog/cpu_top.sv
test/tb_cpu.sv

/* test/tb_cpu.sv */
// Testbench tracks the full 256-byte image across runs and resets the core before every program
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    // One fill and five readbacks of 256 host accesses at 2 cycles each come to about 3.1k
    // cycles, program loads and runs add under 1.5k
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MAX_STEPS      = 200;

    logic              clk      = 1'b0;
    logic              rst_n    = 1'b0;
    logic              en       = 1'b0;
    mem_req_t          host_req = '0;
    logic [DATA_W-1:0] host_rdata;
    logic              host_done;
    logic              halt;
    logic [CC_W-1:0]   cc;

    logic [DATA_W-1:0] img [256];        // Expected DUT memory before a run
    logic [DATA_W-1:0] model_mem [256];  // After a run, per the model
    logic [DATA_W-1:0] bp;               // Program build pointer
    logic [31:0]       rng    = 32'ha715;
    int                cycles = 0;

    cpu_top i_cpu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .host_done  (host_done),
        .halt       (halt),
        .cc         (cc)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error("Timeout: the simulation ran past its cycle limit");
        end
    end

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s: got 0x%02h, expected 0x%02h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_cc(input string name, input logic [CC_W-1:0] got,
                            input logic [CC_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s: got %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s: got %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [DATA_W-1:0] rand_byte();
        rng = xorshift(rng);
        return rng[DATA_W-1:0];
    endfunction

    function automatic logic [1:0] rand_imm();
        rng = xorshift(rng);
        return rng[1:0];
    endfunction

    function automatic logic [DATA_W-1:0] reg_instr(input opcode_t op, input reg_idx_t a,
                                                    input reg_idx_t b);
        return {op, a, b};
    endfunction

    function automatic logic [DATA_W-1:0] sys_instr(input logic [3:0] code);
        return {SYS, code};
    endfunction

    function automatic logic [DATA_W-1:0] branch_instr(input logic [DATA_W-1:0] target);
        opcode_t op;
        op = target[5] ? BGEZ1 : BGEZ0;  // Upper half of the 0..62 window
        return {op, target[4:1]};
    endfunction

    // ISA model on a copy of img, returns retired count or -1 without HALT
    function automatic int run_model();
        logic [DATA_W-1:0] r [4];
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] ir;
        logic [DATA_W-1:0] target;
        logic [1:0]        a;
        logic [1:0]        b;
        logic              halted;
        int                n;
        int                i;

        for (i = 0; i < 256; i = i + 1) begin
            model_mem[i] = img[i];
        end
        r[0]   = 8'd0;
        r[1]   = 8'd1;
        r[2]   = 8'd12;
        r[3]   = 8'd11;
        pc     = RESET_PC;
        halted = 1'b0;
        n      = 0;
        while (!halted && n < MAX_STEPS) begin
            ir = model_mem[pc];
            a  = ir[3:2];
            b  = ir[1:0];
            n  = n + 1;
            case (ir[7:4])
                SYS:     halted = (ir[3:0] == SYS_HALT);
                ADD:     r[0] = r[a] + r[b];
                SUB:     r[0] = r[a] - r[b];
                NEG:     r[0] = 8'd0 - r[a];
                ADDI:    r[a] = r[a] + {6'd0, b};
                LOADI:   r[a] = {6'd0, b};
                MOVE:    r[a] = r[b];
                STORE:   model_mem[r[a]] = r[b];
                LOAD:    r[0] = model_mem[{2'b00, r[3][1:0], ir[3:0]}];
                default: ;
            endcase
            if ((ir[7:4] == BGEZ0 || ir[7:4] == BGEZ1) && !r[0][7]) begin
                pc = {2'b00, ir[4], ir[3:0], 1'b0};
            end else if (ir[7:4] == JUMP) begin
                target = r[a];
                r[3]   = pc + 8'd1;  // Link
                pc     = target;
            end else begin
                pc = pc + 8'd1;
            end
        end
        return halted ? n : -1;
    endfunction

    task automatic host_access(input logic is_write, input logic [DATA_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata);
        @(posedge clk);
        host_req <= '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata};
        @(negedge clk);
        check_bit("host_done early", host_done, 1'b0);
        @(posedge clk);
        host_req <= '0;
        @(negedge clk);
        check_bit("host_done", host_done, 1'b1);  // Exactly one cycle after the request
        rdata = host_rdata;
    endtask

    task automatic poke(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] ignored;
        img[addr] = data;
        host_access(1'b1, addr, data, ignored);
    endtask

    task automatic emit(input logic [DATA_W-1:0] instr);
        poke(bp, instr);
        bp = bp + 8'd1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input string name);
        int                exp_cc;
        int                i;
        logic [DATA_W-1:0] got;

        exp_cc = run_model();
        if (exp_cc < 0) begin
            stop_on_error({name, ": the reference model never reached HALT"});
        end
        apply_reset();
        @(negedge clk);
        check_bit({name, " halt after reset"}, halt, 1'b0);
        check_cc({name, " cc after reset"}, cc, '0);
        @(posedge clk);
        en <= 1'b1;
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        while (!halt) begin
            @(negedge clk);
        end
        check_cc({name, " cc"}, cc, exp_cc[CC_W-1:0]);
        for (i = 0; i < 256; i = i + 1) begin
            host_access(1'b0, i[DATA_W-1:0], '0, got);
            check_data($sformatf("%s mem[%0d]", name, i), got, model_mem[i]);
            img[i] = model_mem[i];
        end
        check_bit({name, " halt held"}, halt, 1'b1);
        check_cc({name, " cc held"}, cc, exp_cc[CC_W-1:0]);
    endtask

    initial begin
        int                i;
        logic [DATA_W-1:0] val;
        logic [DATA_W-1:0] got;

        apply_reset();
        @(negedge clk);
        check_bit("halt after reset", halt, 1'b0);
        check_cc("cc after reset", cc, '0);
        for (i = 0; i < 256; i = i + 1) begin
            poke(i[DATA_W-1:0], rand_byte());
        end
        val = rand_byte();
        poke(8'd200, val);
        host_access(1'b0, 8'd200, '0, got);
        check_data("host_rdata", got, val);

        // Arithmetic, results stored at r3 = 11 upward
        bp = RESET_PC;
        emit(reg_instr(LOADI, 2'd1, rand_imm()));
        emit(reg_instr(LOADI, 2'd2, rand_imm()));
        emit(reg_instr(ADDI, 2'd1, rand_imm()));
        emit(reg_instr(MOVE, 2'd0, 2'd2));
        emit(reg_instr(ADDI, 2'd0, rand_imm()));
        emit(reg_instr(ADD, 2'd1, 2'd0));
        emit(reg_instr(STORE, 2'd3, 2'd0));
        emit(reg_instr(ADDI, 2'd3, 2'd1));
        emit(reg_instr(SUB, 2'd2, 2'd1));  // Usually wraps below zero
        emit(reg_instr(STORE, 2'd3, 2'd0));
        emit(reg_instr(ADDI, 2'd3, 2'd1));
        emit(reg_instr(NEG, 2'd0, 2'd0));
        emit(reg_instr(STORE, 2'd3, 2'd0));
        emit(reg_instr(ADDI, 2'd3, 2'd1));
        emit(reg_instr(STORE, 2'd3, 2'd1));
        emit(reg_instr(ADDI, 2'd3, 2'd1));
        emit(reg_instr(STORE, 2'd3, 2'd2));
        emit(sys_instr(SYS_HALT));
        run_program("arithmetic");

        // LOAD from random pages, copies land at r2 = 13..16
        for (i = 0; i < 32; i = i + 1) begin
            poke(i[DATA_W-1:0], rand_byte());
        end
        bp = RESET_PC;
        for (i = 0; i < 4; i = i + 1) begin
            emit(reg_instr(LOADI, 2'd3, rand_imm()));
            emit({LOAD, rand_imm(), rand_imm()});
            emit(reg_instr(ADDI, 2'd2, 2'd1));
            emit(reg_instr(STORE, 2'd2, 2'd0));
        end
        emit(sys_instr(SYS_HALT));
        run_program("load");

        // Branches, wrong paths leave their own markers
        bp = RESET_PC;
        emit(reg_instr(LOADI, 2'd0, rand_imm()));
        emit(branch_instr(8'd40));
        emit(reg_instr(STORE, 2'd2, 2'd1));
        emit(sys_instr(SYS_HALT));
        bp = 8'd40;
        emit(reg_instr(LOADI, 2'd1, 2'd2));
        emit(reg_instr(STORE, 2'd2, 2'd1));
        emit(reg_instr(NEG, 2'd1, 2'd0));  // r0 = -2
        emit(branch_instr(8'd16));
        emit(reg_instr(ADDI, 2'd2, 2'd1));
        emit(reg_instr(STORE, 2'd2, 2'd0));
        emit(reg_instr(LOADI, 2'd0, 2'd0));
        emit(branch_instr(8'd20));
        emit(sys_instr(SYS_HALT));
        bp = 8'd16;
        emit(reg_instr(STORE, 2'd2, 2'd2));
        emit(sys_instr(SYS_HALT));
        bp = 8'd20;
        emit(reg_instr(ADDI, 2'd2, 2'd1));
        emit(reg_instr(STORE, 2'd2, 2'd3));
        emit(reg_instr(NEG, 2'd2, 2'd0));
        emit(branch_instr(8'd50));
        emit(sys_instr(SYS_HALT));
        bp = 8'd50;
        emit(reg_instr(STORE, 2'd1, 2'd1));
        emit(sys_instr(SYS_HALT));
        run_program("branch");

        // Jump to 24 and back through the link in r3
        bp = RESET_PC;
        emit(reg_instr(LOADI, 2'd1, rand_imm()));
        emit(reg_instr(ADD, 2'd2, 2'd2));
        emit(reg_instr(JUMP, 2'd0, 2'd0));
        emit(reg_instr(STORE, 2'd2, 2'd3));
        emit(reg_instr(ADDI, 2'd1, 2'd2));
        emit(reg_instr(STORE, 2'd1, 2'd0));
        emit(sys_instr(SYS_HALT));
        bp = 8'd24;
        emit(reg_instr(STORE, 2'd1, 2'd3));
        emit(reg_instr(ADDI, 2'd0, 2'd1));
        emit(reg_instr(JUMP, 2'd3, 2'd0));
        run_program("jump");

        // SLEEP counts stay below 8
        bp = RESET_PC;
        emit(reg_instr(LOADI, 2'd0, rand_imm()));
        emit(sys_instr(SYS_SLEEP));
        emit(reg_instr(ADDI, 2'd0, 2'd3));
        emit(sys_instr(SYS_SLEEP));
        emit(sys_instr(SYS_NOP));
        emit(sys_instr(4'b0101));  // Unassigned SYS code
        emit(reg_instr(LOADI, 2'd0, 2'd0));
        emit(sys_instr(SYS_SLEEP));
        emit(reg_instr(STORE, 2'd2, 2'd3));
        emit(sys_instr(SYS_HALT));
        run_program("sleep_halt");

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
// Shared widths, opcodes and request structs; data, address and registers are all DATA_W wide
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;
    localparam int CC_W   = 16;

    localparam logic [DATA_W-1:0] RESET_PC = 8'd33;

    // Power-on register values, index i holds r<i>
    localparam logic [3:0][DATA_W-1:0] REG_INIT = {8'd11, 8'd12, 8'd1, 8'd0};

    typedef logic [1:0] reg_idx_t;

    typedef enum logic [3:0] {
        SYS   = 4'b0000,
        ADD   = 4'b0001,
        ADDI  = 4'b0010,
        SUB   = 4'b0011,
        NEG   = 4'b0110,
        BGEZ0 = 4'b1000,
        BGEZ1 = 4'b1001,
        MOVE  = 4'b1010,
        STORE = 4'b1011,
        LOAD  = 4'b1100,
        LOADI = 4'b1101,
        JUMP  = 4'b1110
    } opcode_t;

    // Low nibble of the SYS group, anything else is a NOP
    localparam logic [3:0] SYS_NOP   = 4'b0000;
    localparam logic [3:0] SYS_SLEEP = 4'b0011;
    localparam logic [3:0] SYS_HALT  = 4'b1111;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_NEG = 2'd3
    } alu_op_t;

    typedef struct packed {
        logic              valid;
        alu_op_t           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } alu_req_t;

    // Shared by core and host side of the memory
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              en;
        reg_idx_t          idx;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

/* verilog/cpu_regfile.sv */
// Four registers r0..r3 with combinational reads; a same-cycle write shows up after the edge
`default_nettype none

module cpu_regfile (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cpu_pkg::reg_idx_t            sel_a,
    input  cpu_pkg::reg_idx_t            sel_b,
    input  cpu_pkg::reg_wr_t             wr,
    output logic [cpu_pkg::DATA_W-1:0]   rd_a,
    output logic [cpu_pkg::DATA_W-1:0]   rd_b,
    output logic [cpu_pkg::DATA_W-1:0]   r0_val,
    output logic [cpu_pkg::DATA_W-1:0]   r3_val
);
    import cpu_pkg::*;

    logic [3:0][DATA_W-1:0] regs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= REG_INIT;
        end else if (wr.en) begin
            regs[wr.idx] <= wr.data;
        end
    end

    assign rd_a   = regs[sel_a];
    assign rd_b   = regs[sel_b];

    // Fixed taps for branch test, SLEEP count and LOAD page
    assign r0_val = regs[0];
    assign r3_val = regs[3];

endmodule

`default_nettype wire

/* verilog/cpu_sequencer.sv */
// Fetch/execute FSM; relies on ALU and memory answering exactly one cycle after each request
`default_nettype none

module cpu_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic [cpu_pkg::DATA_W-1:0]   rd_a,
    input  logic [cpu_pkg::DATA_W-1:0]   rd_b,
    input  logic [cpu_pkg::DATA_W-1:0]   r0_val,
    input  logic [cpu_pkg::DATA_W-1:0]   r3_val,
    input  logic [cpu_pkg::DATA_W-1:0]   alu_result,
    input  logic                         alu_done,
    input  logic [cpu_pkg::DATA_W-1:0]   mem_rdata,
    input  logic                         mem_done,
    output cpu_pkg::alu_req_t            alu_req,
    output cpu_pkg::mem_req_t            core_req,
    output cpu_pkg::reg_wr_t             reg_wr,
    output cpu_pkg::reg_idx_t            sel_a,
    output cpu_pkg::reg_idx_t            sel_b,
    output logic                         running,
    output logic                         halt,
    output logic [cpu_pkg::CC_W-1:0]     cc
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, WAIT, HALTED} state_t;

    state_t            state;
    logic              fetch_wait;  // Second fetch cycle
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] ir;
    logic [DATA_W-1:0] sleep_cnt;
    logic [DATA_W-1:0] pc_next;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] load_addr;
    logic [DATA_W-1:0] branch_addr;
    opcode_t           opcode;
    logic              is_sleep;
    logic              is_halt;
    logic              retire;

    assign opcode      = opcode_t'(ir[7:4]);
    assign sel_a       = ir[3:2];
    assign sel_b       = ir[1:0];
    assign imm         = {{(DATA_W-2){1'b0}}, ir[1:0]};
    assign load_addr   = {2'b00, r3_val[1:0], ir[3:0]};
    assign branch_addr = {2'b00, ir[4], ir[3:0], 1'b0};  // ir[4] picks the upper half
    assign running     = (state == FETCH) || (state == EXEC) || (state == WAIT);

    always_comb begin
        is_sleep = 1'b0;
        is_halt  = 1'b0;
        if (opcode == SYS) begin
            case (ir[3:0])
                SYS_SLEEP: is_sleep = 1'b1;
                SYS_HALT:  is_halt  = 1'b1;
                SYS_NOP:   ;
                default:   ;
            endcase
        end
    end

    // Requests and register writeback
    always_comb begin
        alu_req  = '0;
        core_req = '0;
        reg_wr   = '0;
        case (state)
            FETCH: begin
                core_req.valid = !fetch_wait;
                core_req.addr  = pc;
            end
            EXEC: begin
                case (opcode)
                    ADD, SUB, NEG: begin
                        alu_req.valid = 1'b1;
                        alu_req.op    = (opcode == ADD) ? ALU_ADD :
                                        (opcode == SUB) ? ALU_SUB : ALU_NEG;
                        alu_req.a     = rd_a;
                        alu_req.b     = rd_b;
                    end
                    STORE: begin
                        core_req.valid = 1'b1;
                        core_req.write = 1'b1;
                        core_req.addr  = rd_a;
                        core_req.wdata = rd_b;
                    end
                    LOAD: begin
                        core_req.valid = 1'b1;
                        core_req.addr  = load_addr;
                    end
                    ADDI:  reg_wr = '{en: 1'b1, idx: sel_a, data: rd_a + imm};
                    LOADI: reg_wr = '{en: 1'b1, idx: sel_a, data: imm};
                    MOVE:  reg_wr = '{en: 1'b1, idx: sel_a, data: rd_b};
                    JUMP:  reg_wr = '{en: 1'b1, idx: 2'd3, data: pc + 8'd1};  // Link
                    default: ;
                endcase
            end
            WAIT: begin
                if (alu_done) begin
                    reg_wr = '{en: 1'b1, idx: 2'd0, data: alu_result};
                end else if (mem_done && opcode == LOAD) begin
                    reg_wr = '{en: 1'b1, idx: 2'd0, data: mem_rdata};
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        retire = 1'b0;
        case (state)
            EXEC: retire = !(opcode inside {ADD, SUB, NEG, LOAD, STORE}) &&
                           !(is_sleep && r0_val != '0);
            WAIT: retire = alu_done || mem_done || (is_sleep && sleep_cnt == 8'd1);
            default: ;
        endcase
    end

    always_comb begin
        pc_next = pc + 8'd1;
        if (state == EXEC) begin
            case (opcode)
                BGEZ0, BGEZ1: if (!r0_val[DATA_W-1]) pc_next = branch_addr;
                JUMP:         pc_next = rd_a;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            fetch_wait <= 1'b0;
            pc         <= RESET_PC;
            ir         <= '0;
            cc         <= '0;
            halt       <= 1'b0;
        end else begin
            case (state)
                IDLE: if (en) begin
                    pc    <= RESET_PC;
                    state <= FETCH;
                end
                FETCH: begin
                    fetch_wait <= !fetch_wait;
                    if (fetch_wait) begin
                        ir    <= mem_rdata;
                        state <= EXEC;
                    end
                end
                EXEC: state <= WAIT;  // Overridden below on a one-cycle retire
                default: ;
            endcase
            if (retire) begin
                cc <= cc + 1'b1;
                pc <= pc_next;
                if (is_halt) begin
                    halt  <= 1'b1;
                    state <= HALTED;
                end else begin
                    state <= FETCH;
                end
            end
        end
    end

    // SLEEP countdown, r0 taken unsigned
    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            sleep_cnt <= r0_val;
        end else if (state == WAIT) begin
            sleep_cnt <= sleep_cnt - 8'd1;
        end
    end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
        else $error("halt fell without reset");

    a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_req.valid && core_req.valid))
        else $error("ALU and memory requested together");

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
// Core top level; host_req is only served while the core is idle or halted, never mid-run
`default_nettype none

module cpu_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         en,
    input  cpu_pkg::mem_req_t            host_req,
    output logic [cpu_pkg::DATA_W-1:0]   host_rdata,
    output logic                         host_done,
    output logic                         halt,
    output logic [cpu_pkg::CC_W-1:0]     cc
);
    import cpu_pkg::*;

    alu_req_t          alu_req;
    mem_req_t          core_req;
    reg_wr_t           reg_wr;
    reg_idx_t          sel_a;
    reg_idx_t          sel_b;
    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    logic [DATA_W-1:0] r0_val;
    logic [DATA_W-1:0] r3_val;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] core_rdata;
    logic              alu_done;
    logic              core_done;
    logic              running;

    cpu_sequencer i_cpu_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .r0_val     (r0_val),
        .r3_val     (r3_val),
        .alu_result (alu_result),
        .alu_done   (alu_done),
        .mem_rdata  (core_rdata),
        .mem_done   (core_done),
        .alu_req    (alu_req),
        .core_req   (core_req),
        .reg_wr     (reg_wr),
        .sel_a      (sel_a),
        .sel_b      (sel_b),
        .running    (running),
        .halt       (halt),
        .cc         (cc)
    );

    cpu_regfile i_cpu_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .sel_a  (sel_a),
        .sel_b  (sel_b),
        .wr     (reg_wr),
        .rd_a   (rd_a),
        .rd_b   (rd_b),
        .r0_val (r0_val),
        .r3_val (r3_val)
    );

    r0_alu i_r0_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (alu_req),
        .result (alu_result),
        .done   (alu_done)
    );

    mem_controller i_mem_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .running    (running),
        .core_req   (core_req),
        .host_req   (host_req),
        .core_rdata (core_rdata),
        .host_rdata (host_rdata),
        .core_done  (core_done),
        .host_done  (host_done)
    );

endmodule

`default_nettype wire

/* verilog/mem_controller.sv */
// 256x8 single-port RAM, registered read returning old data on a write; host only when not running
`default_nettype none

module mem_controller (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         running,
    input  cpu_pkg::mem_req_t            core_req,
    input  cpu_pkg::mem_req_t            host_req,
    output logic [cpu_pkg::DATA_W-1:0]   core_rdata,
    output logic [cpu_pkg::DATA_W-1:0]   host_rdata,
    output logic                         core_done,
    output logic                         host_done
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] mem [2**DATA_W];
    logic [DATA_W-1:0] rdata_q;
    mem_req_t          req;

    // Port owner follows the run state
    assign req = running ? core_req : host_req;

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                mem[req.addr] <= req.wdata;
            end
            rdata_q <= mem[req.addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_done <= 1'b0;
            host_done <= 1'b0;
        end else begin
            core_done <= running && core_req.valid;
            host_done <= !running && host_req.valid;
        end
    end

    // Only one side is ever waiting
    assign core_rdata = rdata_q;
    assign host_rdata = rdata_q;

    a_no_host_while_running: assert property (@(posedge clk) disable iff (!rst_n)
        !(running && host_req.valid))
        else $error("host access while the core is running");

endmodule

`default_nettype wire

/* verilog/r0_alu.sv */
// Registered r0 arithmetic, wraps modulo 256; result holds until the next valid request
`default_nettype none

module r0_alu (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cpu_pkg::alu_req_t            req,
    output logic [cpu_pkg::DATA_W-1:0]   result,
    output logic                         done
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (req.valid) begin
            case (req.op)
                ALU_ADD: result <= req.a + req.b;
                ALU_SUB: result <= req.a - req.b;
                ALU_NEG: result <= -req.a;  // Two's complement of r[a]
                default: result <= req.a;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= req.valid;
        end
    end

    a_done_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(req.valid))
        else $error("ALU done without a request");

endmodule

`default_nettype wire
